//--- all.f
src/daq_pkg.sv
src/daq_sys_regs.sv
src/trigger_word_gen.sv
src/hitor_tdc.sv
src/word_fifo.sv
src/rr_arbiter.sv
src/daq_readout_top.sv
tests/tb_daq_readout.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the readout testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_daq_readout \
    -f all.f -o tb_daq_readout > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_daq_readout > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- tests/tb_daq_readout.sv
`timescale 1ns/10ps
`default_nettype none

module tb_daq_readout;

    import daq_pkg::*;

    localparam int FIFO_DEPTH    = 8;
    localparam int DRAIN_TIMEOUT = 4000;

    // Step operations of the stimulus table
    localparam int OP_WRITE = 0;
    localparam int OP_READ  = 1;
    localparam int OP_TRIG  = 2;
    localparam int OP_HITOR = 3;
    localparam int OP_READY = 4;
    localparam int OP_WAIT  = 5;
    localparam int OP_DRAIN = 6;

    logic       bus_clk;
    logic       bus_rst;
    bus_addr_t  bus_add;
    bus_byte_t  bus_wdata;
    bus_byte_t  bus_rdata;
    logic       bus_rd;
    logic       bus_wr;
    logic       rj45_trigger;
    logic       lvds_hitor;
    logic       arb_ready_out;
    logic       arb_write_out;
    data_word_t arb_data_out;

    // Table columns: operation, address or length or level, data or expected
    int step_op[$];
    int step_a[$];
    int step_b[$];

    // Reference model, one expected queue per source
    data_word_t  trig_q[$];
    data_word_t  tdc_q[$];
    int          trig_pushed, trig_delivered, tdc_pushed, tdc_delivered;
    logic        model_en_trig, model_en_tdc;
    logic [30:0] model_trig_num;
    tdc_count_t  model_evt_num;

    int          mismatch_errors, other_errors;
    int          check_mismatches, check_others;
    logic        timed_out;
    logic [31:0] lfsr_state;

    daq_readout_top #(
        .VERSION_MAJOR(8'd3),
        .VERSION_MINOR(8'd7),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) daq_readout_top_inst (
        .bus_clk(bus_clk), .bus_rst(bus_rst), .bus_add(bus_add),
        .bus_wdata(bus_wdata), .bus_rdata(bus_rdata), .bus_rd(bus_rd), .bus_wr(bus_wr),
        .rj45_trigger(rj45_trigger), .lvds_hitor(lvds_hitor),
        .arb_ready_out(arb_ready_out), .arb_write_out(arb_write_out),
        .arb_data_out(arb_data_out)
    );

    initial begin
        bus_clk = 1'b0;
        forever #20 bus_clk = ~bus_clk;
    end

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // One step per bit, LSB first
    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = value | (int'(lfsr_state[0]) << i);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic add_step(input int op, input int a, input int b);
        step_op.push_back(op);
        step_a.push_back(a);
        step_b.push_back(b);
    endtask

    task automatic build_table();
        int toggle, src, gap, len, ready_level;
        // Version readback, control and lost count after reset, unmapped
        add_step(OP_READ, 0, 1);
        add_step(OP_READ, 1, 7);
        add_step(OP_READ, 2, 3);
        add_step(OP_READ, 3, 0);
        add_step(OP_READ, 4, 0);
        add_step(OP_READ, 5, 0);
        add_step(OP_READ, 16'h0123, 0);
        // Trigger only; hit-or pulse must vanish
        add_step(OP_WRITE, 4, 1);
        add_step(OP_READY, 1, 0);
        for (int n = 0; n < 6; n++) begin
            add_step(OP_TRIG, 0, 0);
            add_step(OP_WAIT, 4, 0);
        end
        add_step(OP_HITOR, 5, 0);
        add_step(OP_WAIT, 10, 0);
        add_step(OP_DRAIN, 0, 0);
        // TDC only, last pulse saturates
        add_step(OP_WRITE, 4, 2);
        add_step(OP_TRIG, 0, 0);
        add_step(OP_HITOR, 1, 0);
        add_step(OP_HITOR, 2, 0);
        add_step(OP_HITOR, 17, 0);
        add_step(OP_HITOR, 300, 0);
        add_step(OP_HITOR, 5000, 0);
        add_step(OP_DRAIN, 0, 0);
        // Mixed traffic, LFSR gaps and ready toggles
        add_step(OP_WRITE, 4, 3);
        ready_level = 1;
        for (int n = 0; n < 24; n++) begin
            take_bits(1, toggle);
            if (toggle != 0) begin
                ready_level = 1 - ready_level;
                add_step(OP_READY, ready_level, 0);
            end
            take_bits(1, src);
            if (src != 0) begin
                add_step(OP_TRIG, 0, 0);
            end else begin
                take_bits(4, len);
                add_step(OP_HITOR, 1 + len, 0);
            end
            take_bits(3, gap);
            add_step(OP_WAIT, 2 + gap, 0);
        end
        add_step(OP_READY, 1, 0);
        add_step(OP_DRAIN, 0, 0);
        // Back-pressure: 3 extra triggers and 2 extra hits dropped
        add_step(OP_WRITE, 5, 0);
        add_step(OP_READY, 0, 0);
        for (int n = 0; n < FIFO_DEPTH + 3; n++) begin
            add_step(OP_TRIG, 0, 0);
            add_step(OP_WAIT, 3, 0);
        end
        for (int n = 0; n < FIFO_DEPTH + 2; n++) begin
            add_step(OP_HITOR, 3, 0);
            add_step(OP_WAIT, 3, 0);
        end
        add_step(OP_WAIT, 20, 0);
        add_step(OP_READ, 5, 5);
        add_step(OP_READY, 1, 0);
        add_step(OP_DRAIN, 0, 0);
        add_step(OP_WRITE, 5, 0);
        add_step(OP_READ, 5, 0);
        // Both off, then trigger numbering resumes
        add_step(OP_WRITE, 4, 0);
        add_step(OP_TRIG, 0, 0);
        add_step(OP_HITOR, 6, 0);
        add_step(OP_WAIT, 30, 0);
        add_step(OP_WRITE, 4, 1);
        add_step(OP_READ, 4, 1);
        add_step(OP_TRIG, 0, 0);
        add_step(OP_TRIG, 0, 0);
        add_step(OP_DRAIN, 0, 0);
    endtask

    task automatic reg_write(input int addr, input int data);
        bus_add   = bus_addr_t'(addr);
        bus_wdata = bus_byte_t'(data);
        bus_wr    = 1'b1;
        @(negedge bus_clk);
        bus_wr    = 1'b0;
        if (addr == 4) begin
            model_en_trig = data[0];
            model_en_tdc  = data[1];
        end
    endtask

    // Registered read data is stable by the next falling edge
    task automatic reg_read(input int addr, input int expected);
        bus_add = bus_addr_t'(addr);
        bus_rd  = 1'b1;
        @(negedge bus_clk);
        bus_rd  = 1'b0;
        if (bus_rdata !== bus_byte_t'(expected)) begin
            mismatch_errors++;
            $display("mismatch at %0t: bus_rdata (address %0d) is %h, expected %h",
                     $time, addr, bus_rdata, bus_byte_t'(expected));
        end
    endtask

    task automatic trigger_pulse();
        rj45_trigger = 1'b1;
        repeat (2) @(negedge bus_clk);
        rj45_trigger = 1'b0;
        @(negedge bus_clk);
        // Falling edge before the FIFO write edge, occupancy is final here
        if (model_en_trig) begin
            if (trig_pushed - trig_delivered < FIFO_DEPTH) begin
                trig_q.push_back({1'b1, model_trig_num});
                trig_pushed++;
            end
            model_trig_num++;
        end
        @(negedge bus_clk);
    endtask

    task automatic hitor_pulse(input int length);
        pulse_len_t exp_len;
        exp_len    = (length > 4095) ? 12'd4095 : pulse_len_t'(length);
        lvds_hitor = 1'b1;
        repeat (length) @(negedge bus_clk);
        lvds_hitor = 1'b0;
        // Word goes in 3 cycles after the low level is sampled
        repeat (3) @(negedge bus_clk);
        if (model_en_tdc) begin
            if (tdc_pushed - tdc_delivered < FIFO_DEPTH) begin
                tdc_q.push_back({TDC_IDENTIFIER, model_evt_num, exp_len});
                tdc_pushed++;
            end
            model_evt_num++;
        end
        @(negedge bus_clk);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((trig_q.size() != 0 || tdc_q.size() != 0) && cycles < DRAIN_TIMEOUT) begin
            @(negedge bus_clk);
            cycles++;
        end
        if (trig_q.size() != 0 || tdc_q.size() != 0) begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout at %0t: %0d trigger and %0d TDC words never arrived",
                     $time, trig_q.size(), tdc_q.size());
        end
    endtask

    // Output checker, bit 31 tells the source
    always @(posedge bus_clk) begin
        if (!bus_rst && arb_write_out) begin
            if (!arb_ready_out) begin
                check_others++;
                $display("error at %0t: word written while arb_ready_out is low", $time);
            end
            if (arb_data_out[31]) begin
                trig_delivered++;
                if (trig_q.size() == 0) begin
                    check_others++;
                    $display("error at %0t: unexpected trigger word %h", $time, arb_data_out);
                end else begin
                    if (arb_data_out !== trig_q[0]) begin
                        check_mismatches++;
                        $display("mismatch at %0t: arb_data_out is %h, expected %h",
                                 $time, arb_data_out, trig_q[0]);
                    end
                    void'(trig_q.pop_front());
                end
            end else begin
                tdc_delivered++;
                if (tdc_q.size() == 0) begin
                    check_others++;
                    $display("error at %0t: unexpected TDC word %h", $time, arb_data_out);
                end else begin
                    if (arb_data_out !== tdc_q[0]) begin
                        check_mismatches++;
                        $display("mismatch at %0t: arb_data_out is %h, expected %h",
                                 $time, arb_data_out, tdc_q[0]);
                    end
                    void'(tdc_q.pop_front());
                end
            end
        end
    end

    initial begin
        bus_rst          = 1'b1;
        bus_add          = '0;
        bus_wdata        = '0;
        bus_rd           = 1'b0;
        bus_wr           = 1'b0;
        rj45_trigger     = 1'b0;
        lvds_hitor       = 1'b0;
        arb_ready_out    = 1'b0;
        trig_pushed      = 0;
        trig_delivered   = 0;
        tdc_pushed       = 0;
        tdc_delivered    = 0;
        model_en_trig    = 1'b0;
        model_en_tdc     = 1'b0;
        model_trig_num   = '0;
        model_evt_num    = '0;
        mismatch_errors  = 0;
        other_errors     = 0;
        check_mismatches = 0;
        check_others     = 0;
        timed_out        = 1'b0;
        lfsr_state       = 32'hf7bf;
        build_table();
        repeat (5) @(negedge bus_clk);
        bus_rst = 1'b0;
        if (arb_write_out !== 1'b0) begin
            mismatch_errors++;
            $display("mismatch at %0t: arb_write_out is %b, expected 0", $time, arb_write_out);
        end
        for (int i = 0; i < step_op.size() && !timed_out; i++) begin
            case (step_op[i])
                OP_WRITE: reg_write(step_a[i], step_b[i]);
                OP_READ:  reg_read(step_a[i], step_b[i]);
                OP_TRIG:  trigger_pulse();
                OP_HITOR: hitor_pulse(step_a[i]);
                OP_READY: arb_ready_out = step_a[i][0];
                OP_WAIT:  repeat (step_a[i]) @(negedge bus_clk);
                OP_DRAIN: wait_drain();
                default:  other_errors++;
            endcase
        end
        repeat (5) @(negedge bus_clk);
        mismatch_errors = mismatch_errors + check_mismatches;
        other_errors    = other_errors + check_others;
        $display("error counts: %0d mismatches, %0d other errors",
                 mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/daq_readout_top.sv
`timescale 1ns/10ps
`default_nettype none

module daq_readout_top #(
    parameter daq_pkg::bus_byte_t VERSION_MAJOR = 8'd0,
    parameter daq_pkg::bus_byte_t VERSION_MINOR = 8'd0,
    parameter int                 FIFO_DEPTH    = 8
) (
    input  wire                 bus_clk,
    input  wire                 bus_rst,
    input  wire daq_pkg::bus_addr_t bus_add,
    input  wire daq_pkg::bus_byte_t bus_wdata,
    output daq_pkg::bus_byte_t  bus_rdata,
    input  wire                 bus_rd,
    input  wire                 bus_wr,
    input  wire                 rj45_trigger,
    input  wire                 lvds_hitor,
    input  wire                 arb_ready_out,
    output logic                arb_write_out,
    output daq_pkg::data_word_t arb_data_out
);

    import daq_pkg::*;

    logic       en_trigger, en_tdc;

    // Trigger path
    logic       trigger_wr, trigger_lost, trigger_full, trigger_empty, trigger_rd;
    data_word_t trigger_word, trigger_head;

    // TDC path
    logic       tdc_wr, tdc_lost, tdc_full, tdc_empty, tdc_rd;
    data_word_t tdc_word, tdc_head;

    daq_sys_regs #(
        .VERSION_MAJOR(VERSION_MAJOR),
        .VERSION_MINOR(VERSION_MINOR)
    ) daq_sys_regs_inst (
        .bus_clk(bus_clk), .bus_rst(bus_rst), .bus_add(bus_add),
        .bus_wdata(bus_wdata), .bus_rd(bus_rd), .bus_wr(bus_wr),
        .bus_rdata(bus_rdata), .trigger_lost(trigger_lost), .tdc_lost(tdc_lost),
        .en_trigger(en_trigger), .en_tdc(en_tdc)
    );

    // Stands in for the TLU trigger numbering
    trigger_word_gen trigger_word_gen_inst (
        .bus_clk(bus_clk), .bus_rst(bus_rst), .enable(en_trigger),
        .trigger_in(rj45_trigger), .fifo_full(trigger_full),
        .wr(trigger_wr), .word(trigger_word), .lost(trigger_lost)
    );

    hitor_tdc hitor_tdc_inst (
        .bus_clk(bus_clk), .bus_rst(bus_rst), .enable(en_tdc),
        .hitor_in(lvds_hitor), .fifo_full(tdc_full),
        .wr(tdc_wr), .word(tdc_word), .lost(tdc_lost)
    );

    word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) trigger_fifo (
        .bus_clk(bus_clk), .bus_rst(bus_rst), .wr(trigger_wr), .wr_data(trigger_word),
        .rd(trigger_rd), .rd_data(trigger_head), .empty(trigger_empty), .full(trigger_full)
    );

    word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tdc_fifo (
        .bus_clk(bus_clk), .bus_rst(bus_rst), .wr(tdc_wr), .wr_data(tdc_word),
        .rd(tdc_rd), .rd_data(tdc_head), .empty(tdc_empty), .full(tdc_full)
    );

    // Merge onto the downstream FIFO
    rr_arbiter rr_arbiter_inst (
        .bus_clk(bus_clk), .bus_rst(bus_rst),
        .trigger_empty(trigger_empty), .trigger_head(trigger_head),
        .tdc_empty(tdc_empty), .tdc_head(tdc_head),
        .trigger_rd(trigger_rd), .tdc_rd(tdc_rd),
        .arb_ready_out(arb_ready_out), .arb_write_out(arb_write_out),
        .arb_data_out(arb_data_out)
    );

endmodule

`default_nettype wire

//--- src/rr_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter (
    input  wire                 bus_clk,
    input  wire                 bus_rst,
    input  wire                 trigger_empty,
    input  wire daq_pkg::data_word_t trigger_head,
    input  wire                 tdc_empty,
    input  wire daq_pkg::data_word_t tdc_head,
    output logic                trigger_rd,
    output logic                tdc_rd,
    input  wire                 arb_ready_out,
    output logic                arb_write_out,
    output daq_pkg::data_word_t arb_data_out
);

    import daq_pkg::*;

    arb_state_t last_q;
    logic       grant_trigger;
    logic       grant_tdc;

    // Alternate when both wait, else serve whichever has data
    always_comb begin
        grant_trigger = 1'b0;
        grant_tdc     = 1'b0;
        if (!trigger_empty && !tdc_empty) begin
            if (last_q == GRANT_TRIGGER) begin
                grant_tdc = 1'b1;
            end else begin
                grant_trigger = 1'b1;
            end
        end else if (!trigger_empty) begin
            grant_trigger = 1'b1;
        end else if (!tdc_empty) begin
            grant_tdc = 1'b1;
        end
    end

    // Nothing moves without downstream ready
    assign trigger_rd    = arb_ready_out && grant_trigger;
    assign tdc_rd        = arb_ready_out && grant_tdc;
    assign arb_write_out = trigger_rd || tdc_rd;
    assign arb_data_out  = grant_tdc ? tdc_head : trigger_head;

    // Updated only on an actual transfer
    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            last_q <= GRANT_TDC;
        end else if (trigger_rd) begin
            last_q <= GRANT_TRIGGER;
        end else if (tdc_rd) begin
            last_q <= GRANT_TDC;
        end
    end

    one_grant: assert property (
        @(posedge bus_clk) disable iff (bus_rst)
        $onehot0({trigger_rd, tdc_rd})
    ) else $error("both FIFOs popped in one cycle");

endmodule

`default_nettype wire

//--- src/word_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module word_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                 bus_clk,
    input  wire                 bus_rst,
    input  wire                 wr,
    input  wire daq_pkg::data_word_t wr_data,
    input  wire                 rd,
    output daq_pkg::data_word_t rd_data,
    output logic                empty,
    output logic                full
);

    import daq_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    // Wrap logic relies on a power-of-two depth
    if (FIFO_DEPTH != (2 ** AW)) begin : g_depth_check
        $error("word_fifo: FIFO_DEPTH must be a power of two");
    end

    data_word_t    mem [FIFO_DEPTH];
    // Extra MSB tells full from empty
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;

    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (wr) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    // Show-ahead head word
    assign rd_data = mem[rd_ptr[AW-1:0]];
    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Arbiter only pops a non-empty FIFO
    no_underflow: assert property (
        @(posedge bus_clk) disable iff (bus_rst) rd |-> !empty
    ) else $error("word_fifo read while empty");

    // Producer drops words instead of overrunning
    no_overflow: assert property (
        @(posedge bus_clk) disable iff (bus_rst) wr |-> !full
    ) else $error("word_fifo write while full");

endmodule

`default_nettype wire

//--- src/hitor_tdc.sv
`timescale 1ns/10ps
`default_nettype none

module hitor_tdc (
    input  wire                 bus_clk,
    input  wire                 bus_rst,
    input  wire                 enable,
    input  wire                 hitor_in,
    input  wire                 fifo_full,
    output logic                wr,
    output daq_pkg::data_word_t word,
    output logic                lost
);

    import daq_pkg::*;

    logic [2:0] sync_q;
    logic       rise;
    logic       fall;
    logic       armed_q;
    logic       measure;
    logic       pend_q;
    pulse_len_t len_q;
    tdc_count_t evt_cnt;

    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[1:0], hitor_in};
        end
    end

    assign rise = sync_q[1] && !sync_q[2];
    assign fall = !sync_q[1] && sync_q[2];

    // Length counts cycles with the synchronized input high
    // Armed only if the pulse began while enabled
    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            len_q   <= '0;
            armed_q <= 1'b0;
        end else if (rise) begin
            len_q   <= 12'd1;
            armed_q <= enable;
        end else begin
            if (sync_q[1] && (len_q != '1)) begin
                len_q <= len_q + 12'd1;
            end
            if (fall) begin
                armed_q <= 1'b0;
            end
        end
    end

    // Disabling mid-pulse also drops the pulse
    assign measure = fall && armed_q && enable;

    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            pend_q  <= 1'b0;
            evt_cnt <= '0;
        end else begin
            pend_q <= measure;
            if (measure) begin
                evt_cnt <= evt_cnt + 16'd1;
            end
        end
    end

    // Identifier, event number, length
    always_ff @(posedge bus_clk) begin
        if (measure) begin
            word <= {TDC_IDENTIFIER, evt_cnt, len_q};
        end
    end

    assign wr   = pend_q && !fifo_full;
    assign lost = pend_q && fifo_full;

    // Every measured pulse is at least one cycle long
    nonzero_length: assert property (
        @(posedge bus_clk) disable iff (bus_rst)
        wr |-> (word[11:0] != '0)
    ) else $error("TDC word written with zero length");

endmodule

`default_nettype wire

//--- src/trigger_word_gen.sv
`timescale 1ns/10ps
`default_nettype none

module trigger_word_gen (
    input  wire                 bus_clk,
    input  wire                 bus_rst,
    input  wire                 enable,
    input  wire                 trigger_in,
    input  wire                 fifo_full,
    output logic                wr,
    output daq_pkg::data_word_t word,
    output logic                lost
);

    // [0] and [1] synchronize and [2] holds the edge history
    logic [2:0]  sync_q;
    logic        rise;
    logic        pend_q;
    logic [30:0] trig_cnt;

    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[1:0], trigger_in};
        end
    end

    assign rise = sync_q[1] && !sync_q[2];

    // Edges seen while disabled leave the count alone
    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            pend_q   <= 1'b0;
            trig_cnt <= '0;
        end else begin
            pend_q <= rise && enable;
            if (rise && enable) begin
                trig_cnt <= trig_cnt + 31'd1;
            end
        end
    end

    // Number taken before the increment, so first word is 0
    always_ff @(posedge bus_clk) begin
        if (rise && enable) begin
            word <= {1'b1, trig_cnt};
        end
    end

    // Full checked in the write cycle itself
    // Dropped words still used up their number
    assign wr   = pend_q && !fifo_full;
    assign lost = pend_q && fifo_full;

    // Each accepted edge ends in exactly one of write or drop
    wr_lost_onehot: assert property (
        @(posedge bus_clk) disable iff (bus_rst)
        (rise && enable) |=> (wr ^ lost)
    ) else $error("trigger edge gave no word or both write and lost");

endmodule

`default_nettype wire

//--- src/daq_sys_regs.sv
`timescale 1ns/10ps
`default_nettype none

module daq_sys_regs #(
    parameter daq_pkg::bus_byte_t VERSION_MAJOR = 8'd0,
    parameter daq_pkg::bus_byte_t VERSION_MINOR = 8'd0
) (
    input  wire                 bus_clk,
    input  wire                 bus_rst,
    input  wire daq_pkg::bus_addr_t bus_add,
    input  wire daq_pkg::bus_byte_t bus_wdata,
    input  wire                 bus_rd,
    input  wire                 bus_wr,
    output daq_pkg::bus_byte_t  bus_rdata,
    input  wire                 trigger_lost,
    input  wire                 tdc_lost,
    output logic                en_trigger,
    output logic                en_tdc
);

    import daq_pkg::*;

    bus_byte_t  lost_count;
    logic [1:0] lost_inc;
    logic [8:0] lost_sum;
    logic       lost_clr;

    // Both producers may drop in the same cycle
    assign lost_inc = {1'b0, trigger_lost} + {1'b0, tdc_lost};
    assign lost_sum = {1'b0, lost_count} + {7'd0, lost_inc};
    assign lost_clr = bus_wr && (bus_add == REG_LOST_COUNT);

    // Source enables
    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            en_trigger <= 1'b0;
            en_tdc     <= 1'b0;
        end else if (bus_wr && (bus_add == REG_CONTROL)) begin
            en_trigger <= bus_wdata[0];
            en_tdc     <= bus_wdata[1];
        end
    end

    // Lost-word counter, sticks at 255
    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            lost_count <= '0;
        end else if (lost_clr) begin
            lost_count <= '0;
        end else if (lost_sum[8]) begin
            lost_count <= 8'hff;
        end else begin
            lost_count <= lost_sum[7:0];
        end
    end

    // Read data held until the next read strobe
    always_ff @(posedge bus_clk) begin
        if (bus_rd) begin
            case (bus_add)
                REG_VERSION:       bus_rdata <= MODULE_VERSION;
                REG_VERSION_MINOR: bus_rdata <= VERSION_MINOR;
                REG_VERSION_MAJOR: bus_rdata <= VERSION_MAJOR;
                REG_BOARD:         bus_rdata <= BOARD_SIM;
                REG_CONTROL:       bus_rdata <= {6'd0, en_tdc, en_trigger};
                REG_LOST_COUNT:    bus_rdata <= lost_count;
                default:           bus_rdata <= '0;
            endcase
        end
    end

    // Only a bus clear may bring the count down
    lost_count_monotonic: assert property (
        @(posedge bus_clk) disable iff (bus_rst)
        !lost_clr |=> (lost_count >= $past(lost_count))
    ) else $error("lost word count decreased without a clear");

endmodule

`default_nettype wire

//--- src/daq_pkg.sv
`default_nettype none

package daq_pkg;

    // Readout stream word
    typedef logic [31:0] data_word_t;

    // Register bus
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_byte_t;

    // Hit-or length in bus cycles, saturating
    typedef logic [11:0] pulse_len_t;

    // Running hit-or event number
    typedef logic [15:0] tdc_count_t;

    // Top nibble of every TDC word
    // Bit 31 stays 0, trigger words always have it set
    localparam logic [3:0] TDC_IDENTIFIER = 4'd2;

    // Register map
    localparam bus_addr_t REG_VERSION       = 16'd0;
    localparam bus_addr_t REG_VERSION_MINOR = 16'd1;
    localparam bus_addr_t REG_VERSION_MAJOR = 16'd2;
    localparam bus_addr_t REG_BOARD         = 16'd3;
    // Bit 0 trigger enable, bit 1 TDC enable
    localparam bus_addr_t REG_CONTROL       = 16'd4;
    // Read the lost-word count, any write clears it
    localparam bus_addr_t REG_LOST_COUNT    = 16'd5;

    // Readback constants
    localparam bus_byte_t MODULE_VERSION = 8'd1;
    localparam bus_byte_t BOARD_SIM      = 8'd0;

    // Arbiter memory of the last served source
    typedef enum logic {
        GRANT_TRIGGER,
        GRANT_TDC
    } arb_state_t;

endpackage : daq_pkg

`default_nettype wire
